// ==== rtl/function_generator_pkg.sv ====
// ----------------------------------------------------------------------
// shared constants, register map and bus structs for the function generator
// import with a wildcard in the module header
// ----------------------------------------------------------------------
`default_nettype none

package function_generator_pkg;

	// ----------------------------------------------------------------------
	// spi framing
	// command8 + address16 + data32
	localparam int FRAME_BITS = 56;
	// bits in before the address is complete
	localparam int LOOKUP_BITS = 24;
	localparam int BIT_COUNT_BITS = $clog2(FRAME_BITS + 1);
	// pin synchronizer depth
	localparam int SCK_SYNC_STAGES = 2;

	// only this command writes, anything else is a read
	localparam logic [7:0] COMMAND_WRITE = 8'h01;

	// ----------------------------------------------------------------------
	// waveform store geometry
	// 256 words of 32 bits
	localparam int WAVE_WORD_ADDR_BITS = 8;
	// same store seen as 1024 bytes
	localparam int WAVE_BYTE_ADDR_BITS = 10;

	// register map, low two address bits
	localparam logic [1:0] REG_START = 2'd0;
	localparam logic [1:0] REG_END = 2'd1;
	localparam logic [1:0] REG_ENABLE = 2'd2;
	localparam logic [1:0] REG_PASSES = 2'd3;

	// downstream serializer buffer depth
	localparam int CREDIT_MAX = 4;
	localparam int CREDIT_BITS = $clog2(CREDIT_MAX + 1);

	// ----------------------------------------------------------------------
	typedef logic [31:0] reg_word_t;

	// one full spi transaction, msb first on the wire
	typedef struct packed {
		logic [7:0] command;
		logic [15:0] address;
		reg_word_t data;
	} spi_frame_t;

	// one byte to the serializer
	typedef struct packed {
		logic sync;
		logic [7:0] data;
	} sample_t;

endpackage

`default_nettype wire

// ==== rtl/spi_command_slave.sv ====
// ----------------------------------------------------------------------
// mode 0 spi slave, oversampled in the clock_ro domain
// receives 56 bit frames, returns the addressed word in the data phase
// ----------------------------------------------------------------------
`default_nettype none

module spi_command_slave
	import function_generator_pkg::*;
(
	input logic clock_ro,
	input logic reset4_word_clock,
	input logic sclk,
	input logic mosi,
	input logic cs_n,
	output logic miso,
	output spi_frame_t frame,
	output logic frame_valid,
	output logic [15:0] lookup_address,
	input reg_word_t lookup_data
);

	// pin synchronizers
	logic [SCK_SYNC_STAGES-1:0] sclk_sync;
	logic [SCK_SYNC_STAGES-1:0] mosi_sync;
	logic [SCK_SYNC_STAGES-1:0] cs_sync;
	logic sclk_prev;
	logic sclk_s;
	logic mosi_s;
	logic selected;
	logic sclk_rise;
	logic sclk_fall;
	logic data_phase;

	// frame assembly
	logic [BIT_COUNT_BITS-1:0] bit_count;
	logic [FRAME_BITS-2:0] shift_in;
	// [0] address out, [1] storage answered
	logic [1:0] lookup_stage;
	logic [30:0] shift_out;

	assign sclk_s = sclk_sync[SCK_SYNC_STAGES-1];
	assign mosi_s = mosi_sync[SCK_SYNC_STAGES-1];
	assign selected = ~cs_sync[SCK_SYNC_STAGES-1];
	assign sclk_rise = selected & sclk_s & ~sclk_prev;
	assign sclk_fall = selected & ~sclk_s & sclk_prev;
	// falling edges that move on to the next read bit
	assign data_phase = (bit_count > BIT_COUNT_BITS'(LOOKUP_BITS))
		&& (bit_count < BIT_COUNT_BITS'(FRAME_BITS));

	// ----------------------------------------------------------------------
	// control side
	always_ff @(posedge clock_ro) begin
		if (reset4_word_clock) begin
			sclk_sync <= '0;
			cs_sync <= '1;
			sclk_prev <= 1'b0;
			bit_count <= '0;
			lookup_stage <= '0;
			frame_valid <= 1'b0;
			miso <= 1'b0;
		end else begin
			sclk_sync <= {sclk_sync[SCK_SYNC_STAGES-2:0], sclk};
			cs_sync <= {cs_sync[SCK_SYNC_STAGES-2:0], cs_n};
			sclk_prev <= sclk_s;
			frame_valid <= 1'b0;
			lookup_stage <= {lookup_stage[0], 1'b0};
			if (!selected) begin
				// partial frame just dies here
				bit_count <= '0;
				lookup_stage <= '0;
				miso <= 1'b0;
			end else begin
				// count stops at a full frame until chip select rises
				if (sclk_rise && bit_count != BIT_COUNT_BITS'(FRAME_BITS)) begin
					bit_count <= bit_count + 1'b1;
					if (bit_count == BIT_COUNT_BITS'(LOOKUP_BITS - 1)) begin
						lookup_stage[0] <= 1'b1;
					end
					if (bit_count == BIT_COUNT_BITS'(FRAME_BITS - 1)) begin
						frame_valid <= 1'b1;
					end
				end
				// msb goes out well before the falling edge after bit 24
				if (lookup_stage[1]) begin
					miso <= lookup_data[31];
				end else if (sclk_fall && data_phase) begin
					miso <= shift_out[30];
				end
			end
		end
	end

	// ----------------------------------------------------------------------
	// payload shifters
	always_ff @(posedge clock_ro) begin
		mosi_sync <= {mosi_sync[SCK_SYNC_STAGES-2:0], mosi};
		if (sclk_rise) begin
			shift_in <= {shift_in[FRAME_BITS-3:0], mosi_s};
			// address field complete with this bit
			if (bit_count == BIT_COUNT_BITS'(LOOKUP_BITS - 1)) begin
				lookup_address <= {shift_in[14:0], mosi_s};
			end
			if (bit_count == BIT_COUNT_BITS'(FRAME_BITS - 1)) begin
				frame <= spi_frame_t'({shift_in, mosi_s});
			end
		end
		// rest of the read word, one bit per falling edge
		if (lookup_stage[1]) begin
			shift_out <= lookup_data[30:0];
		end else if (sclk_fall && data_phase) begin
			shift_out <= {shift_out[29:0], 1'b0};
		end
	end

endmodule

`default_nettype wire

// ==== rtl/control_registers.sv ====
// ----------------------------------------------------------------------
// playback control registers behind the first spi chip select
// start, end, enable and a read-only pass counter
// ----------------------------------------------------------------------
`default_nettype none

module control_registers
	import function_generator_pkg::*;
(
	input logic clock_ro,
	input logic reset4_word_clock,
	input spi_frame_t frame,
	input logic frame_valid,
	input logic [15:0] lookup_address,
	output reg_word_t lookup_data,
	output logic [WAVE_BYTE_ADDR_BITS-1:0] start_address,
	output logic [WAVE_BYTE_ADDR_BITS-1:0] end_address,
	output logic enable,
	input logic pass_done
);

	reg_word_t start_word;
	reg_word_t end_word;
	reg_word_t enable_word;
	reg_word_t passes;
	logic write;

	// storage decides, not the slave
	assign write = frame_valid && (frame.command == COMMAND_WRITE);

	// full words kept so readback matches what was written
	assign start_address = start_word[WAVE_BYTE_ADDR_BITS-1:0];
	assign end_address = end_word[WAVE_BYTE_ADDR_BITS-1:0];
	assign enable = enable_word[0];

	always_ff @(posedge clock_ro) begin
		if (reset4_word_clock) begin
			start_word <= '0;
			end_word <= '0;
			enable_word <= '0;
			passes <= '0;
		end else begin
			if (write) begin
				// only address bits 1:0 decoded
				case (frame.address[1:0])
					REG_START: start_word <= frame.data;
					REG_END: end_word <= frame.data;
					REG_ENABLE: enable_word <= frame.data;
					// pass counter ignores writes
					default: ;
				endcase
			end
			if (pass_done) begin
				passes <= passes + 1'b1;
			end
		end
	end

	// registered readback, one cycle after the address
	always_ff @(posedge clock_ro) begin
		case (lookup_address[1:0])
			REG_START: lookup_data <= start_word;
			REG_END: lookup_data <= end_word;
			REG_ENABLE: lookup_data <= enable_word;
			REG_PASSES: lookup_data <= passes;
			default: lookup_data <= '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== rtl/waveform_memory.sv ====
// ----------------------------------------------------------------------
// waveform store, 32 bit words from spi and bytes out to playback
// byte 0 of a word is bits 31:24
// ----------------------------------------------------------------------
`default_nettype none

module waveform_memory
	import function_generator_pkg::*;
(
	input logic clock_ro,
	input spi_frame_t frame,
	input logic frame_valid,
	input logic [15:0] lookup_address,
	output reg_word_t lookup_data,
	input logic [WAVE_BYTE_ADDR_BITS-1:0] byte_address,
	input logic byte_read,
	output logic [7:0] byte_data
);

	localparam int WORDS = 1 << WAVE_WORD_ADDR_BITS;

	reg_word_t memory [WORDS];

	logic write;
	logic [WAVE_WORD_ADDR_BITS-1:0] write_word;
	logic [WAVE_WORD_ADDR_BITS-1:0] lookup_word;
	logic [WAVE_WORD_ADDR_BITS-1:0] read_word;

	// playback side, word plus byte lane held from the read
	reg_word_t byte_word_q;
	logic [1:0] byte_lane_q;

	assign write = frame_valid && (frame.command == COMMAND_WRITE);
	assign write_word = frame.address[WAVE_WORD_ADDR_BITS-1:0];
	assign lookup_word = lookup_address[WAVE_WORD_ADDR_BITS-1:0];
	assign read_word = byte_address[WAVE_BYTE_ADDR_BITS-1:2];

	// ----------------------------------------------------------------------
	// spi port, write and readback
	always_ff @(posedge clock_ro) begin
		if (write) begin
			memory[write_word] <= frame.data;
		end
		lookup_data <= memory[lookup_word];
	end

	// ----------------------------------------------------------------------
	// playback port
	always_ff @(posedge clock_ro) begin
		if (byte_read) begin
			byte_word_q <= memory[read_word];
			byte_lane_q <= byte_address[1:0];
		end
	end

	// big endian lane select
	// lane 0 -> 31:24, lane 3 -> 7:0
	assign byte_data = byte_word_q[{~byte_lane_q, 3'b000} +: 8];

endmodule

`default_nettype wire

// ==== rtl/playback_sequencer.sv ====
// ----------------------------------------------------------------------
// steps through the programmed byte range and streams samples out
// one memory read per credit, sync on the first byte of each pass
// ----------------------------------------------------------------------
`default_nettype none

module playback_sequencer
	import function_generator_pkg::*;
(
	input logic clock_ro,
	input logic reset4_word_clock,
	input logic [WAVE_BYTE_ADDR_BITS-1:0] start_address,
	input logic [WAVE_BYTE_ADDR_BITS-1:0] end_address,
	input logic enable,
	output logic [WAVE_BYTE_ADDR_BITS-1:0] byte_address,
	output logic byte_read,
	input logic [7:0] byte_data,
	output logic pass_done,
	output sample_t sample,
	output logic sample_valid,
	input logic credit_return
);

	logic active;
	logic first_pending;
	logic sync_q;
	logic [CREDIT_BITS-1:0] credits;
	logic [WAVE_BYTE_ADDR_BITS-1:0] current_address;
	logic [WAVE_BYTE_ADDR_BITS-1:0] start_latched;
	logic [WAVE_BYTE_ADDR_BITS-1:0] end_latched;
	logic range_ok;
	logic last_byte;

	// empty or inverted range never issues
	assign range_ok = end_latched > start_latched;
	assign last_byte = current_address == (end_latched - 1'b1);

	// enable low stops issue this very cycle
	assign byte_read = enable && active && range_ok && (credits != '0);
	assign byte_address = current_address;

	// memory byte lands one cycle after issue, sync rides alongside
	assign sample = '{sync: sync_q, data: byte_data};

	// ----------------------------------------------------------------------
	always_ff @(posedge clock_ro) begin
		if (reset4_word_clock) begin
			active <= 1'b0;
			first_pending <= 1'b0;
			credits <= CREDIT_BITS'(CREDIT_MAX);
			current_address <= '0;
			start_latched <= '0;
			end_latched <= '0;
			sample_valid <= 1'b0;
			pass_done <= 1'b0;
		end else begin
			sample_valid <= byte_read;
			pass_done <= byte_read && last_byte;

			// issue takes one, serializer gives one back
			case ({byte_read, credit_return})
				2'b10: credits <= credits - 1'b1;
				2'b01: credits <= credits + 1'b1;
				default: ;
			endcase

			if (!enable) begin
				active <= 1'b0;
			end else if (!active) begin
				// fresh pass after enable rises
				active <= 1'b1;
				start_latched <= start_address;
				end_latched <= end_address;
				current_address <= start_address;
				first_pending <= 1'b1;
			end else if (byte_read) begin
				first_pending <= 1'b0;
				if (last_byte) begin
					// wrap, new range takes effect here
					start_latched <= start_address;
					end_latched <= end_address;
					current_address <= start_address;
					first_pending <= 1'b1;
				end else begin
					current_address <= current_address + 1'b1;
				end
			end
		end
	end

	// sync flag for the byte in flight
	always_ff @(posedge clock_ro) begin
		if (byte_read) begin
			sync_q <= first_pending;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/function_generator_top.sv ====
// ----------------------------------------------------------------------
// spi-pollable function generator: registers on one chip select,
// waveform memory on the other, credit-based byte stream out
// ----------------------------------------------------------------------
`default_nettype none

module function_generator_top
	import function_generator_pkg::*;
(
	input logic clock_ro,
	input logic reset4_word_clock,
	input logic spi_sclk,
	input logic spi_mosi,
	input logic spi_cs_registers_n,
	input logic spi_cs_waveform_n,
	output logic spi_miso,
	output sample_t sample,
	output logic sample_valid,
	input logic credit_return,
	output logic ready
);

	// register side
	spi_frame_t frame_registers;
	logic frame_valid_registers;
	logic [15:0] lookup_address_registers;
	reg_word_t lookup_data_registers;
	logic miso_registers;

	// waveform side
	spi_frame_t frame_waveform;
	logic frame_valid_waveform;
	logic [15:0] lookup_address_waveform;
	reg_word_t lookup_data_waveform;
	logic miso_waveform;

	// playback
	logic [WAVE_BYTE_ADDR_BITS-1:0] start_address;
	logic [WAVE_BYTE_ADDR_BITS-1:0] end_address;
	logic enable;
	logic pass_done;
	logic [WAVE_BYTE_ADDR_BITS-1:0] byte_address;
	logic byte_read;
	logic [7:0] byte_data;

	// ----------------------------------------------------------------------
	spi_command_slave registers_spi (
		.clock_ro, .reset4_word_clock,
		.sclk(spi_sclk), .mosi(spi_mosi), .cs_n(spi_cs_registers_n),
		.miso(miso_registers),
		.frame(frame_registers), .frame_valid(frame_valid_registers),
		.lookup_address(lookup_address_registers), .lookup_data(lookup_data_registers)
	);

	spi_command_slave waveform_spi (
		.clock_ro, .reset4_word_clock,
		.sclk(spi_sclk), .mosi(spi_mosi), .cs_n(spi_cs_waveform_n),
		.miso(miso_waveform),
		.frame(frame_waveform), .frame_valid(frame_valid_waveform),
		.lookup_address(lookup_address_waveform), .lookup_data(lookup_data_waveform)
	);

	control_registers registers (
		.clock_ro, .reset4_word_clock,
		.frame(frame_registers), .frame_valid(frame_valid_registers),
		.lookup_address(lookup_address_registers), .lookup_data(lookup_data_registers),
		.start_address, .end_address, .enable, .pass_done
	);

	waveform_memory memory (
		.clock_ro,
		.frame(frame_waveform), .frame_valid(frame_valid_waveform),
		.lookup_address(lookup_address_waveform), .lookup_data(lookup_data_waveform),
		.byte_address, .byte_read, .byte_data
	);

	playback_sequencer sequencer (
		.clock_ro, .reset4_word_clock,
		.start_address, .end_address, .enable,
		.byte_address, .byte_read, .byte_data,
		.pass_done, .sample, .sample_valid, .credit_return
	);

	// ----------------------------------------------------------------------
	// miso from whichever slave is selected, idle low
	assign spi_miso = !spi_cs_registers_n ? miso_registers :
		!spi_cs_waveform_n ? miso_waveform : 1'b0;

	// ready one cycle after reset drops
	always_ff @(posedge clock_ro) begin
		if (reset4_word_clock) begin
			ready <= 1'b0;
		end else begin
			ready <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== tests/function_generator_tb.sv ====
// ----------------------------------------------------------------------
// testbench for the function generator, spi host, credit return and stream model
// operations come from tests/function_generator_stimulus.txt, run from the project root
// ----------------------------------------------------------------------
`default_nettype none

module function_generator_tb
	import function_generator_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	// sck half period in clock_ro cycles
	localparam int SCK_HALF = 8;
	localparam int WORDS = 1 << WAVE_WORD_ADDR_BITS;
	// one frame plus chip select setup and gap
	localparam int FRAME_CYCLES = FRAME_BITS * 2 * SCK_HALF + 4 * SCK_HALF;

	logic clock_ro = 1'b0;
	logic reset4_word_clock;
	logic spi_sclk;
	logic spi_mosi;
	logic spi_cs_registers_n;
	logic spi_cs_waveform_n;
	logic spi_miso;
	sample_t sample;
	logic sample_valid;
	logic credit_return;
	logic ready;

	// stimulus lines, one entry per operation
	string op_q[$];
	string name_q[$];
	int cs_q[$];
	reg_word_t address_q[$];
	reg_word_t data_q[$];
	reg_word_t expect_q[$];

	// ----------------------------------------------------------------------
	// reference model state
	reg_word_t register_mirror [4];
	reg_word_t wave_mirror [WORDS];
	logic [WAVE_BYTE_ADDR_BITS-1:0] next_address;
	logic [WAVE_BYTE_ADDR_BITS-1:0] pass_end;
	logic next_sync;
	// enable rises seen by the host vs handled by the monitor
	int enable_count = 0;
	int enable_seen = 0;
	int passes_completed = 0;

	// credit bookkeeping
	int samples_received = 0;
	int credits_returned = 0;
	bit paused = 1'b0;
	bit returning = 1'b0;
	int unsigned lcg_state = 15;
	int timeout_cycles = 0;

	function_generator_top DUT (
		.clock_ro, .reset4_word_clock,
		.spi_sclk, .spi_mosi, .spi_cs_registers_n, .spi_cs_waveform_n,
		.spi_miso, .sample, .sample_valid, .credit_return, .ready
	);

	// 4 ns period
	always #2 clock_ro = ~clock_ro;

	// ----------------------------------------------------------------------
	task automatic abort_run();
		$display("Something failed");
		$fatal(1, "simulation stopped on the first error");
	endtask

	task automatic check_word(input string name, input reg_word_t expected,
		input reg_word_t actual);
		if (actual !== expected) begin
			$display("FAILED %s expected %h actual %h", name, expected, actual);
			abort_run();
		end
	endtask

	task automatic check_sample(input string name, input sample_t expected,
		input sample_t actual);
		if (actual !== expected) begin
			$display("FAILED %s expected sync %b data %h actual sync %b data %h",
				name, expected.sync, expected.data, actual.sync, actual.data);
			abort_run();
		end
	endtask

	function automatic int unsigned next_random();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	// byte 0 of a word plays first
	function automatic sample_t expected_sample();
		reg_word_t word;
		sample_t expected;
		word = wave_mirror[next_address[WAVE_BYTE_ADDR_BITS-1:2]];
		expected.sync = next_sync;
		case (next_address[1:0])
			2'd0: expected.data = word[31:24];
			2'd1: expected.data = word[23:16];
			2'd2: expected.data = word[15:8];
			default: expected.data = word[7:0];
		endcase
		return expected;
	endfunction

	// range comes from the register mirror at each pass start
	function automatic void start_pass();
		next_address = register_mirror[REG_START][WAVE_BYTE_ADDR_BITS-1:0];
		pass_end = register_mirror[REG_END][WAVE_BYTE_ADDR_BITS-1:0];
		next_sync = 1'b1;
	endfunction

	function automatic void advance_model();
		if (next_address == pass_end - WAVE_BYTE_ADDR_BITS'(1)) begin
			passes_completed++;
			start_pass();
		end else begin
			next_address = next_address + WAVE_BYTE_ADDR_BITS'(1);
			next_sync = 1'b0;
		end
	endfunction

	// host side copy of every write, passes register is read-only
	function automatic void apply_write(input int cs, input spi_frame_t frame_out);
		if (frame_out.command == COMMAND_WRITE) begin
			if (cs != 0) begin
				wave_mirror[frame_out.address[WAVE_WORD_ADDR_BITS-1:0]] = frame_out.data;
			end else if (frame_out.address[1:0] != REG_PASSES) begin
				if (frame_out.address[1:0] == REG_ENABLE && frame_out.data[0]
					&& !register_mirror[REG_ENABLE][0]) begin
					enable_count++;
				end
				register_mirror[frame_out.address[1:0]] = frame_out.data;
			end
		end
	endfunction

	// mode 0 frame, msb first, read data comes back in the last 32 bits
	task automatic spi_transfer(input int cs, input spi_frame_t frame_out,
		output reg_word_t readback);
		logic [FRAME_BITS-1:0] bits;
		bits = frame_out;
		readback = '0;
		@(negedge clock_ro);
		spi_cs_registers_n = (cs != 0);
		spi_cs_waveform_n = (cs == 0);
		for (int i = FRAME_BITS - 1; i >= 0; i--) begin
			spi_mosi = bits[i];
			repeat (SCK_HALF) @(negedge clock_ro);
			// host samples miso as sck rises
			if (i < 32) begin
				readback = {readback[30:0], spi_miso};
			end
			spi_sclk = 1'b1;
			// mirror leads the dut by the synchronizer delay
			if (i == 0) begin
				apply_write(cs, frame_out);
			end
			repeat (SCK_HALF) @(negedge clock_ro);
			spi_sclk = 1'b0;
		end
		repeat (SCK_HALF) @(negedge clock_ro);
		spi_cs_registers_n = 1'b1;
		spi_cs_waveform_n = 1'b1;
		repeat (2 * SCK_HALF) @(negedge clock_ro);
	endtask

	// ----------------------------------------------------------------------
	// stream monitor, outputs settle by the falling edge
	always @(negedge clock_ro) begin
		if (sample_valid) begin
			if (enable_count == 0) begin
				$display("sample_valid was seen before playback was enabled");
				abort_run();
			end else begin
				if (enable_seen != enable_count) begin
					enable_seen = enable_count;
					start_pass();
				end
				check_sample($sformatf("playback_sample_%0d", samples_received),
					expected_sample(), sample);
				advance_model();
				samples_received++;
				if (samples_received - credits_returned > CREDIT_MAX) begin
					$display("more than CREDIT_MAX samples arrived without a credit");
					abort_run();
				end
			end
		end
	end

	// credit return after 0 to 7 cycles
	initial begin
		int delay;
		credit_return = 1'b0;
		forever begin
			@(negedge clock_ro);
			credit_return = 1'b0;
			if (!paused && samples_received > credits_returned) begin
				returning = 1'b1;
				delay = int'((next_random() >> 16) % 32'd8);
				repeat (delay) @(negedge clock_ro);
				credit_return = 1'b1;
				credits_returned++;
				returning = 1'b0;
			end
		end
	end

	initial begin
		wait (timeout_cycles != 0);
		repeat (timeout_cycles) @(posedge clock_ro);
		$display("watchdog expired after %0d cycles", timeout_cycles);
		abort_run();
	end

	// ----------------------------------------------------------------------
	initial begin
		int fd;
		int fields;
		int cs;
		int budget;
		int samples_expected;
		int target;
		string line;
		string op;
		string name;
		reg_word_t address;
		reg_word_t data;
		reg_word_t expected;
		reg_word_t readback;
		spi_frame_t frame_out;

		reset4_word_clock = 1'b1;
		spi_sclk = 1'b0;
		spi_mosi = 1'b0;
		spi_cs_registers_n = 1'b1;
		spi_cs_waveform_n = 1'b1;
		samples_expected = 0;
		budget = 40;
		foreach (register_mirror[i]) begin
			register_mirror[i] = '0;
		end

		fd = $fopen("tests/function_generator_stimulus.txt", "r");
		if (fd == 0) begin
			$display("could not open the stimulus file");
			abort_run();
		end else begin
			while (!$feof(fd)) begin
				fields = $fgets(line, fd);
				fields = $sscanf(line, "%s %d %h %h %h %s",
					op, cs, address, data, expected, name);
				// comment and blank lines fall out here
				if (fields == 6) begin
					op_q.push_back(op);
					cs_q.push_back(cs);
					address_q.push_back(address);
					data_q.push_back(data);
					expect_q.push_back(expected);
					name_q.push_back(name);
				end
			end
			$fclose(fd);
		end

		// run length from the operations themselves
		foreach (op_q[i]) begin
			budget += 200;
			if (op_q[i] == "w" || op_q[i] == "r" || op_q[i] == "p") begin
				budget += FRAME_CYCLES;
			end else if (op_q[i] == "e") begin
				samples_expected += int'(data_q[i]);
			end else if (op_q[i] == "q") begin
				budget += int'(data_q[i]);
			end
		end
		timeout_cycles = budget + 40 * samples_expected;

		// reset, ready and stream must stay low
		repeat (16) begin
			@(negedge clock_ro);
			if (ready !== 1'b0 || sample_valid !== 1'b0) begin
				$display("ready or sample_valid was high during reset");
				abort_run();
			end
		end
		reset4_word_clock = 1'b0;
		@(negedge clock_ro);
		if (ready !== 1'b1) begin
			$display("ready did not rise one cycle after reset");
			abort_run();
		end

		foreach (op_q[i]) begin
			frame_out.command = (op_q[i] == "w") ? COMMAND_WRITE : 8'h00;
			frame_out.address = address_q[i][15:0];
			frame_out.data = (op_q[i] == "w") ? data_q[i] : '0;
			if (op_q[i] == "w") begin
				spi_transfer(cs_q[i], frame_out, readback);
			end else if (op_q[i] == "r") begin
				spi_transfer(cs_q[i], frame_out, readback);
				check_word(name_q[i], expect_q[i], readback);
			end else if (op_q[i] == "p") begin
				// stream is quiet, every issued last byte has arrived
				spi_transfer(0, frame_out, readback);
				check_word(name_q[i], reg_word_t'(passes_completed), readback);
			end else if (op_q[i] == "e") begin
				target = samples_received + int'(data_q[i]);
				wait (samples_received >= target);
			end else if (op_q[i] == "h") begin
				// all credits held downstream, address frozen
				paused = 1'b1;
				wait (samples_received - credits_returned == CREDIT_MAX && !returning);
			end else if (op_q[i] == "g") begin
				paused = 1'b0;
			end else if (op_q[i] == "q") begin
				target = samples_received;
				repeat (int'(data_q[i])) @(negedge clock_ro);
				if (samples_received != target) begin
					$display("samples kept arriving after playback was disabled");
					abort_run();
				end
			end else begin
				$display("unknown stimulus operation %s", op_q[i]);
				abort_run();
			end
		end

		$display("Everything OK");
		$finish;
	end

endmodule

`default_nettype wire

// ==== list.f ====
rtl/function_generator_pkg.sv
rtl/spi_command_slave.sv
rtl/control_registers.sv
rtl/waveform_memory.sv
rtl/playback_sequencer.sv
rtl/function_generator_top.sv
tests/function_generator_tb.sv

// ==== Makefile ====
SIM      ?= verilator
FLAGS    ?= --binary --timing -j 0
TOP      ?= function_generator_tb
FILELIST ?= list.f
BUILD    ?= obj_dir

.PHONY: simulate clean

# the run's exit status is the pass or fail result
simulate:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)
	./$(BUILD)/V$(TOP)

clean:
	rm -rf $(BUILD)

// ==== tests/function_generator_stimulus.txt ====
# op cs address data expected name; cs 0 registers, 1 waveform; numbers in hex
# w write, r read and compare, e wait for data samples, h hold credits, g give back, q quiet for data cycles, p check passes
w 0 0000 00000123 00000000 start_write
w 0 0001 000000a5 00000000 end_write
w 0 0002 00000002 00000000 enable_write_bit0_clear
w 0 0003 deadbeef 00000000 passes_write
r 0 0000 00000000 00000123 start_readback
r 0 0001 00000000 000000a5 end_readback
r 0 0002 00000000 00000002 enable_readback
r 0 0003 00000000 00000000 passes_ignores_write
w 1 0000 00112233 00000000 wave_write_0
w 1 0001 44556677 00000000 wave_write_1
w 1 0002 8899aabb 00000000 wave_write_2
w 1 0003 ccddeeff 00000000 wave_write_3
w 1 0004 10203040 00000000 wave_write_4
r 1 0002 00000000 8899aabb wave_readback_2
r 1 0001 00000000 44556677 wave_readback_1
r 1 0003 00000000 ccddeeff wave_readback_3
r 1 0000 00000000 00112233 wave_readback_0
r 1 0004 00000000 10203040 wave_readback_4
w 0 0000 00000004 00000000 start_4
w 0 0001 0000000c 00000000 end_12
w 0 0002 00000001 00000000 enable_on
e 0 0000 00000018 00000000 playback_three_passes
h 0 0000 00000000 00000000 hold_credits
w 0 0000 00000008 00000000 start_8
w 0 0001 00000010 00000000 end_16
r 0 0000 00000000 00000008 start_8_readback
g 0 0000 00000000 00000000 release_credits
e 0 0000 00000020 00000000 playback_new_range
w 0 0002 00000000 00000000 enable_off
q 0 0000 00000064 00000000 quiet_after_disable
p 0 0003 00000000 00000000 passes_after_disable
w 0 0002 00000001 00000000 enable_again
e 0 0000 00000010 00000000 playback_restart
w 0 0002 00000000 00000000 enable_off_again
q 0 0000 00000064 00000000 quiet_again
p 0 0003 00000000 00000000 passes_final
